// ==== compile.f ====
rtl/rv_branch_pkg.sv
rtl/branch_decoder.sv
rtl/branch_regfile.sv
rtl/target_address_generator.sv
rtl/branch_unit_top.sv
sim/branch_unit_tb.sv

// ==== sim/branch_vectors.txt ====
# L <reg idx> <data>
# I <name> <instr> <addr> <next addr> <flag> <target> <writeback> <exception>
L 01 00001000
L 02 00000005
L 03 00000005
L 04 fffffff0
L 00 deadbeef
I jal_fwd 1000046f 00000100 00000200 1 00000200 00000104 0
I jal_mispredict 1000006f 00000100 00000104 1 00000200 00000104 4
I jal_back ff9ff06f 00000400 000003f8 1 000003f8 00000404 0
I jal_half_misalign 1000006f 00000101 00000201 1 00000201 00000105 1
I jalr_clear_bit0 005084e7 00000300 00001004 1 00001004 00000304 0
I jalr_link 00048067 00000320 00000304 1 00000304 00000324 0
I jalr_after_jal 00040067 00000330 00000104 1 00000104 00000334 0
I jalr_word_misalign 00208067 00000310 00001002 1 00001002 00000314 2
I x0_link_first 04000067 00000500 00000040 1 00000040 00000504 0
I x0_link_second 04000067 00000510 00000040 1 00000040 00000514 0
I beq_taken 00310863 00000600 00000610 1 00000610 00000000 0
I beq_not 00410863 00000600 00000604 1 00000604 00000000 0
I bne_taken 00411863 00000600 00000610 1 00000610 00000000 0
I bne_not 00311863 00000600 00000604 1 00000604 00000000 0
I blt_taken 00224863 00000600 00000610 1 00000610 00000000 0
I blt_not 00414863 00000600 00000604 1 00000604 00000000 0
I bge_taken 00415863 00000600 00000610 1 00000610 00000000 0
I bge_not 00225863 00000600 00000604 1 00000604 00000000 0
I bltu_taken 00416863 00000600 00000610 1 00000610 00000000 0
I bltu_not 00226863 00000600 00000604 1 00000604 00000000 0
I bgeu_equal 00317863 00000600 00000610 1 00000610 00000000 0
I bgeu_not 00417863 00000600 00000604 1 00000604 00000000 0
I bgeu_taken_neg 00227863 00000600 00000610 1 00000610 00000000 0
I beq_backward fe0008e3 00000700 000006f0 1 000006f0 00000000 0
I bne_mispredict 00311863 00000600 00000610 1 00000604 00000000 4
I func3_2 00312863 00000600 00000604 0 00000000 00000000 8
I func3_3 00313863 00000600 00000604 0 00000000 00000000 8
I non_control 00108093 00000600 00000604 0 00000000 00000000 0

// ==== sim/branch_unit_tb.sv ====
// run from the project root, vectors come from sim/branch_vectors.txt
// every instruction is followed by one bubble cycle so its link write lands first
`timescale 1ns/1ps

module branch_unit_tb;

	import rv_branch_pkg::*;

	localparam int    clock_period = 20;	// ns
	localparam int    rand_pairs   = 8;	// random blt/bgeu operand pairs
	localparam string vector_file  = "sim/branch_vectors.txt";

	logic                 clock_i;
	logic                 reset_i;
	logic [31:0]          instruction_i;
	logic [xlen-1:0]      instruction_addr_i;
	logic [xlen-1:0]      instruction_next_addr_i;
	logic                 load_en_i;
	logic [reg_idx_w-1:0] load_idx_i;
	logic [xlen-1:0]      load_data_i;
	logic                 flag_jump_o;
	logic [xlen-1:0]      addr_target_o;
	logic [xlen-1:0]      addr_writeback_o;
	exception_t           exception_o;

	int          error_count = 0;	// individual check failures
	int          test_count  = 0;
	int          fail_count  = 0;
	int          limit_cycles = 0;
	bit          watchdog_armed = 1'b0;
	logic [31:0] lfsr_state = 32'h89e66bb6;

	branch_unit_top #(
		.depth (32)
	) i_branch_unit_top (
		.clock_i                 (clock_i),
		.reset_i                 (reset_i),
		.instruction_i           (instruction_i),
		.instruction_addr_i      (instruction_addr_i),
		.instruction_next_addr_i (instruction_next_addr_i),
		.load_en_i               (load_en_i),
		.load_idx_i              (load_idx_i),
		.load_data_i             (load_data_i),
		.flag_jump_o             (flag_jump_o),
		.addr_target_o           (addr_target_o),
		.addr_writeback_o        (addr_writeback_o),
		.exception_o             (exception_o)
	);

	initial begin
		clock_i = 1'b0;
		forever #(clock_period / 2) clock_i = ~clock_i;
	end

	// compare tasks
	// ------------------------------
	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s flag expected %b actual %b", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input string field,
			input logic [xlen-1:0] exp, input logic [xlen-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
			error_count++;
		end
	endtask

	task automatic check_exception(input string name, input exception_t exp,
			input exception_t act);
		if (act !== exp) begin
			$display("MISMATCH %s exception expected %b actual %b", name, exp, act);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("PASS %s", name);
		end else begin
			fail_count++;
			$display("FAIL %s", name);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic random_word(output logic [31:0] word);
		word = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit
			word = {word[30:0], lfsr_state[0]};
		end
	endtask

	// drivers, each starts and ends 1 ns after a rising edge
	// ------------------------------
	task automatic load_register(input logic [reg_idx_w-1:0] idx, input logic [xlen-1:0] data);
		load_en_i   = 1'b1;
		load_idx_i  = idx;
		load_data_i = data;
		@(posedge clock_i);
		#1;
		load_en_i = 1'b0;
	endtask

	task automatic run_instruction(input string name, input logic [31:0] instr,
			input logic [xlen-1:0] addr, input logic [xlen-1:0] next,
			input logic exp_flag, input logic [xlen-1:0] exp_target,
			input logic [xlen-1:0] exp_wb, input exception_t exp_exc);
		int errors_before;
		errors_before           = error_count;
		instruction_i           = instr;
		instruction_addr_i      = addr;
		instruction_next_addr_i = next;	// held through the output cycle for bit 2
		@(posedge clock_i);
		#1;
		check_flag(name, exp_flag, flag_jump_o);
		check_addr(name, "target", exp_target, addr_target_o);
		check_addr(name, "writeback", exp_wb, addr_writeback_o);
		check_exception(name, exp_exc, exception_o);
		instruction_i = '0;	// bubble, link write happens on the next edge
		@(posedge clock_i);
		#1;
		report_test(name, errors_before);
	endtask

	// counts L and I lines for the watchdog budget
	task automatic count_vectors(output int count);
		int    fd;
		int    code;
		string line;
		count = 0;
		fd = $fopen(vector_file, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0 && (line[0] == "L" || line[0] == "I"))
					count++;
			end
			$fclose(fd);
		end
	endtask

	// watchdog
	// ------------------------------
	initial begin
		wait (watchdog_armed);
		repeat (limit_cycles) @(posedge clock_i);
		$display("timeout: run did not finish within %0d cycles", limit_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	// stimulus
	// ------------------------------
	initial begin : stimulus
		int              fd;
		int              code;
		int              vector_count;
		int              errors_before;
		string           kind;
		string           name;
		string           line;
		logic [31:0]     instr;
		logic [xlen-1:0] addr;
		logic [xlen-1:0] next;
		logic [xlen-1:0] target;
		logic [xlen-1:0] wb;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic            flag;
		logic            taken;
		exception_t      exc;
		logic [reg_idx_w-1:0] idx;
		logic [xlen-1:0] data;

		reset_i                 = 1'b1;
		instruction_i           = 32'h1000_046f;	// jal x8 held through reset
		instruction_addr_i      = 32'h0000_0100;
		instruction_next_addr_i = '0;
		load_en_i               = 1'b0;
		load_idx_i              = '0;
		load_data_i             = '0;

		count_vectors(vector_count);
		limit_cycles   = (vector_count + rand_pairs * 4) * 4 + 100;
		watchdog_armed = 1'b1;

		repeat (8) @(posedge clock_i);
		#1;

		// reset must keep the outputs at zero against a live jal
		errors_before = error_count;
		check_flag("reset_state", 1'b0, flag_jump_o);
		check_addr("reset_state", "target", '0, addr_target_o);
		check_addr("reset_state", "writeback", '0, addr_writeback_o);
		check_exception("reset_state", '0, exception_o);
		report_test("reset_state", errors_before);

		reset_i            = 1'b0;
		instruction_i      = '0;
		instruction_addr_i = '0;

		fd = $fopen(vector_file, "r");
		if (fd == 0) begin
			$display("could not open vector file %s", vector_file);
			error_count++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", kind);
				if (code != 1)
					break;
				if (kind[0] == "#") begin
					code = $fgets(line, fd);	// comment, drop the rest
				end else if (kind == "L") begin
					code = $fscanf(fd, "%h %h", idx, data);
					if (code == 2) begin
						load_register(idx, data);
					end else begin
						$display("malformed register load line in vector file");
						error_count++;
						code = $fgets(line, fd);
					end
				end else if (kind == "I") begin
					code = $fscanf(fd, "%s %h %h %h %h %h %h %h",
						name, instr, addr, next, flag, target, wb, exc);
					if (code == 8) begin
						run_instruction(name, instr, addr, next, flag, target, wb, exc);
					end else begin
						$display("malformed instruction line in vector file");
						error_count++;
						code = $fgets(line, fd);
					end
				end else begin
					$display("unknown line type %s in vector file", kind);
					error_count++;
					code = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end

		// random operands in x5/x6, offset +16
		// ------------------------------
		for (int i = 0; i < rand_pairs; i++) begin
			random_word(a);
			random_word(b);
			if (i % 4 == 3)
				b = a;	// equal operands now and then
			load_register(5'd5, a);
			load_register(5'd6, b);
			addr = 32'h0000_2000 + i * 32;

			// signed less-than: differing signs decide on the sign of a
			taken  = (a[31] != b[31]) ? a[31] : (a < b);
			target = taken ? addr + 32'd16 : addr + 32'd4;
			run_instruction($sformatf("rand_blt_%0d", i), 32'h0062_c863, addr, target,
				1'b1, target, '0, '0);

			taken  = (a >= b);	// unsigned, equal is taken
			target = taken ? addr + 32'd16 : addr + 32'd4;
			run_instruction($sformatf("rand_bgeu_%0d", i), 32'h0062_f863, addr, target,
				1'b1, target, '0, '0);
		end

		$display("tests %0d  failed %0d  check errors %0d", test_count, fail_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== rtl/branch_unit_top.sv ====
// link write lands one edge after the result register, so the linked value is
// readable by the instruction presented after that edge
`timescale 1ns/1ps

module branch_unit_top #(
	parameter int depth = 32	// register file entries
) (
	input  logic                                 clock_i,
	input  logic                                 reset_i,
	input  logic [31:0]                          instruction_i,
	input  logic [rv_branch_pkg::xlen-1:0]       instruction_addr_i,
	input  logic [rv_branch_pkg::xlen-1:0]       instruction_next_addr_i,
	input  logic                                 load_en_i,
	input  logic [rv_branch_pkg::reg_idx_w-1:0]  load_idx_i,
	input  logic [rv_branch_pkg::xlen-1:0]       load_data_i,
	output logic                                 flag_jump_o,
	output logic [rv_branch_pkg::xlen-1:0]       addr_target_o,
	output logic [rv_branch_pkg::xlen-1:0]       addr_writeback_o,
	output rv_branch_pkg::exception_t            exception_o
);

	import rv_branch_pkg::*;

	encoding_e            encoding;
	logic [2:0]           func3;
	logic [reg_idx_w-1:0] rs1;
	logic [reg_idx_w-1:0] rs2;
	logic [reg_idx_w-1:0] rd;
	logic [xlen-1:0]      immediate;
	logic [xlen-1:0]      src1;
	logic [xlen-1:0]      src2;

	logic [reg_idx_w-1:0] rd_q;	// rd aligned with the generator outputs
	logic                 is_link_q;	// jal or jalr in the output stage
	logic                 link_en;

	// decode
	// ------------------------------
	branch_decoder i_decoder (
		.instruction_i (instruction_i),
		.encoding_o    (encoding),
		.func3_o       (func3),
		.rs1_o         (rs1),
		.rs2_o         (rs2),
		.rd_o          (rd),
		.immediate_o   (immediate)
	);

	// operands, plus link writeback
	// ------------------------------
	branch_regfile #(
		.depth (depth)
	) i_regfile (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.rs1_i       (rs1),
		.rs2_i       (rs2),
		.src1_o      (src1),
		.src2_o      (src2),
		.link_en_i   (link_en),
		.link_idx_i  (rd_q),
		.link_data_i (addr_writeback_o),
		.load_en_i   (load_en_i),
		.load_idx_i  (load_idx_i),
		.load_data_i (load_data_i)
	);

	// resolution
	// ------------------------------
	target_address_generator i_tag (
		.clock_i                 (clock_i),
		.reset_i                 (reset_i),
		.encoding_i              (encoding),
		.func3_i                 (func3),
		.instruction_addr_i      (instruction_addr_i),
		.instruction_next_addr_i (instruction_next_addr_i),
		.src1_operand_i          (src1),
		.src2_operand_i          (src2),
		.immediate_i             (immediate),
		.flag_jump_o             (flag_jump_o),
		.addr_target_o           (addr_target_o),
		.addr_writeback_o        (addr_writeback_o),
		.exception_o             (exception_o)
	);

	// rd delay stage
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i)
			is_link_q <= 1'b0;
		else
			is_link_q <= (encoding == enc_jal) || (encoding == enc_jalr);
	end

	always_ff @(posedge clock_i) begin
		rd_q <= rd;	// only used when is_link_q is set
	end

	// branches carry immediate bits in the rd slot, hence the is_link_q mask
	assign link_en = flag_jump_o & is_link_q & (rd_q != '0);

endmodule

// ==== rtl/target_address_generator.sv ====
// one result per cycle, no handshake; mispredict compares against the next
// address seen in the output cycle, so that bit is combinational
`timescale 1ns/1ps

module target_address_generator (
	input  logic                              clock_i,
	input  logic                              reset_i,
	input  rv_branch_pkg::encoding_e          encoding_i,
	input  logic [2:0]                        func3_i,
	input  logic [rv_branch_pkg::xlen-1:0]    instruction_addr_i,
	input  logic [rv_branch_pkg::xlen-1:0]    instruction_next_addr_i,
	input  logic [rv_branch_pkg::xlen-1:0]    src1_operand_i,
	input  logic [rv_branch_pkg::xlen-1:0]    src2_operand_i,
	input  logic [rv_branch_pkg::xlen-1:0]    immediate_i,
	output logic                              flag_jump_o,
	output logic [rv_branch_pkg::xlen-1:0]    addr_target_o,
	output logic [rv_branch_pkg::xlen-1:0]    addr_writeback_o,
	output rv_branch_pkg::exception_t         exception_o
);

	import rv_branch_pkg::*;

	logic            flag_jump_q;
	logic [xlen-1:0] addr_target_q;
	logic [xlen-1:0] addr_writeback_q;
	logic            exc_func3_q;	// registered illegal branch variant

	logic [xlen-1:0] addr_seq;	// fall-through address
	logic [xlen-1:0] addr_rel;	// pc relative target
	logic [xlen-1:0] addr_reg;	// register relative sum, jalr
	logic            branch_taken;
	logic            func3_legal;

	// address adders
	// ------------------------------
	assign addr_seq = instruction_addr_i + 32'd4;
	assign addr_rel = instruction_addr_i + immediate_i;	// immediate already in bytes
	assign addr_reg = src1_operand_i + immediate_i;

	// branch compare
	// ------------------------------
	always_comb begin
		branch_taken = 1'b0;
		func3_legal  = 1'b1;

		case (func3_i)
			f3_beq:  branch_taken = (src1_operand_i == src2_operand_i);
			f3_bne:  branch_taken = (src1_operand_i != src2_operand_i);
			f3_blt:  branch_taken = ($signed(src1_operand_i) < $signed(src2_operand_i));
			f3_bge:  branch_taken = ($signed(src1_operand_i) >= $signed(src2_operand_i));
			f3_bltu: branch_taken = (src1_operand_i < src2_operand_i);
			f3_bgeu: branch_taken = (src1_operand_i >= src2_operand_i);	// taken on equal
			default: func3_legal  = 1'b0;	// codes 2 and 3
		endcase
	end

	// resolution register
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			flag_jump_q      <= 1'b0;
			addr_target_q    <= '0;
			addr_writeback_q <= '0;
			exc_func3_q      <= 1'b0;
		end else begin
			// non-control encodings leave everything at zero
			flag_jump_q      <= 1'b0;
			addr_target_q    <= '0;
			addr_writeback_q <= '0;
			exc_func3_q      <= 1'b0;

			case (encoding_i)
				enc_jal: begin
					flag_jump_q      <= 1'b1;
					addr_target_q    <= addr_rel;
					addr_writeback_q <= addr_seq;	// return address
				end

				enc_jalr: begin
					flag_jump_q      <= 1'b1;
					addr_target_q    <= {addr_reg[xlen-1:1], 1'b0};	// isa clears bit 0
					addr_writeback_q <= addr_seq;
				end

				enc_branch: begin
					if (func3_legal) begin
						flag_jump_q   <= 1'b1;
						addr_target_q <= branch_taken ? addr_rel : addr_seq;
					end else begin
						exc_func3_q   <= 1'b1;	// flag stays low
					end
				end

				default: ;
			endcase
		end
	end

	// outputs
	// ------------------------------
	assign flag_jump_o      = flag_jump_q;
	assign addr_target_o    = addr_target_q;
	assign addr_writeback_o = addr_writeback_q;

	assign exception_o[exc_func3]         = exc_func3_q;
	assign exception_o[exc_mispredict]    = flag_jump_q &
		(addr_target_q != instruction_next_addr_i);	// fetch went elsewhere
	assign exception_o[exc_word_misalign] = flag_jump_q & addr_target_q[1];
	assign exception_o[exc_half_misalign] = flag_jump_q & addr_target_q[0];

	// an illegal branch must never also report a jump
	a_func3_excl_flag: assert property (
		@(posedge clock_i) disable iff (reset_i)
		!(exception_o[exc_func3] && flag_jump_o)
	) else $error("exc_func3 raised together with flag_jump");

endmodule

// ==== rtl/branch_regfile.sv ====
// x0 is hardwired zero and has no storage; two async reads, load port beats
// the link port when both hit the same register on one edge
`timescale 1ns/1ps

module branch_regfile #(
	parameter int depth = 32
) (
	input  logic                                 clock_i,
	input  logic                                 reset_i,
	input  logic [rv_branch_pkg::reg_idx_w-1:0]  rs1_i,
	input  logic [rv_branch_pkg::reg_idx_w-1:0]  rs2_i,
	output logic [rv_branch_pkg::xlen-1:0]       src1_o,
	output logic [rv_branch_pkg::xlen-1:0]       src2_o,
	input  logic                                 link_en_i,
	input  logic [rv_branch_pkg::reg_idx_w-1:0]  link_idx_i,
	input  logic [rv_branch_pkg::xlen-1:0]       link_data_i,
	input  logic                                 load_en_i,
	input  logic [rv_branch_pkg::reg_idx_w-1:0]  load_idx_i,
	input  logic [rv_branch_pkg::xlen-1:0]       load_data_i
);

	import rv_branch_pkg::*;

	logic [xlen-1:0] regs [1:depth-1];	// x1 .. x(depth-1)

	logic link_hit;
	logic load_hit;

	// x0 and out of range indices never land in the array
	assign link_hit = link_en_i && (link_idx_i != '0) && (link_idx_i < depth);
	assign load_hit = load_en_i && (load_idx_i != '0) && (load_idx_i < depth);

	// write side
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 1; i < depth; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (link_hit)
				regs[link_idx_i] <= link_data_i;	// jal/jalr return address
			if (load_hit)
				regs[load_idx_i] <= load_data_i;	// later assignment wins same index
		end
	end

	// read side, asynchronous
	// ------------------------------
	assign src1_o = (rs1_i == '0 || rs1_i >= depth) ? '0 : regs[rs1_i];
	assign src2_o = (rs2_i == '0 || rs2_i >= depth) ? '0 : regs[rs2_i];

	// load and link on the same register, the loaded value must win
	a_load_beats_link: assert property (
		@(posedge clock_i) disable iff (reset_i)
		(load_hit && link_hit && load_idx_i == link_idx_i)
		|=> (regs[$past(load_idx_i)] == $past(load_data_i))
	) else $error("link write overrode a test load on the same register");

endmodule

// ==== rtl/branch_decoder.sv ====
// pure combinational decode; only jal, jalr and the b-type branches are known,
// every other opcode yields enc_none and a zero immediate
`timescale 1ns/1ps

module branch_decoder (
	input  logic [31:0]               instruction_i,
	output rv_branch_pkg::encoding_e  encoding_o,
	output logic [2:0]                func3_o,
	output logic [rv_branch_pkg::reg_idx_w-1:0] rs1_o,
	output logic [rv_branch_pkg::reg_idx_w-1:0] rs2_o,
	output logic [rv_branch_pkg::reg_idx_w-1:0] rd_o,
	output logic [rv_branch_pkg::xlen-1:0]      immediate_o
);

	import rv_branch_pkg::*;

	logic [6:0]      opcode;
	logic [xlen-1:0] imm_j;	// jal offset, bytes
	logic [xlen-1:0] imm_i;	// jalr offset
	logic [xlen-1:0] imm_b;	// branch offset, bytes

	// instruction fields
	// ------------------------------
	assign opcode  = instruction_i[6:0];
	assign func3_o = instruction_i[14:12];
	assign rs1_o   = instruction_i[19:15];
	assign rs2_o   = instruction_i[24:20];
	assign rd_o    = instruction_i[11:7];	// garbage for branches, top level masks it

	// immediates
	// ------------------------------
	// j-type: imm[20|10:1|11|19:12], lsb is always zero
	assign imm_j = {
		{11{instruction_i[31]}},
		instruction_i[31],
		instruction_i[19:12],
		instruction_i[20],
		instruction_i[30:21],
		1'b0
	};

	// i-type: imm[11:0] straight from the top bits
	assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};

	// b-type: imm[12|10:5] in the funct7 slot, imm[4:1|11] in the rd slot
	assign imm_b = {
		{19{instruction_i[31]}},
		instruction_i[31],
		instruction_i[7],
		instruction_i[30:25],
		instruction_i[11:8],
		1'b0
	};

	// class select
	// ------------------------------
	always_comb begin
		encoding_o  = enc_none;	// default, non-control
		immediate_o = '0;

		case (opcode)
			op_jal: begin
				encoding_o  = enc_jal;
				immediate_o = imm_j;
			end

			op_jalr: begin
				// func3 of jalr is not checked here
				encoding_o  = enc_jalr;
				immediate_o = imm_i;
			end

			op_branch: begin
				encoding_o  = enc_branch;
				immediate_o = imm_b;	// func3 legality judged downstream
			end

			default: begin
				encoding_o  = enc_none;
				immediate_o = '0;
			end
		endcase
	end

endmodule

// ==== rtl/rv_branch_pkg.sv ====
// shared encodings for the rv32i branch slice; encoding values are internal
// and only need to stay distinct, func3 and opcode codes follow the isa
package rv_branch_pkg;

	// widths
	// ------------------------------
	localparam int xlen      = 32;	// data and address width
	localparam int reg_idx_w = 5;	// register index width

	// instruction class, as wide as the original encoding bus
	typedef enum logic [15:0] {
		enc_none   = 16'h0000,	// anything that is not a control transfer
		enc_jal    = 16'h0001,
		enc_jalr   = 16'h0002,
		enc_branch = 16'h0004
	} encoding_e;

	// branch variants, codes 2 and 3 are left unnamed on purpose (illegal)
	typedef enum logic [2:0] {
		f3_beq  = 3'b000,
		f3_bne  = 3'b001,
		f3_blt  = 3'b100,
		f3_bge  = 3'b101,
		f3_bltu = 3'b110,
		f3_bgeu = 3'b111
	} branch_func3_e;

	// exception flags
	// ------------------------------
	typedef logic [3:0] exception_t;

	localparam int exc_func3         = 3;	// unknown func3 on a branch
	localparam int exc_mispredict    = 2;	// next address differs from target
	localparam int exc_word_misalign = 1;	// target bit 1 set
	localparam int exc_half_misalign = 0;	// target bit 0 set

	// major opcodes, instruction[6:0]
	// ------------------------------
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;

endpackage
